/* hw/hc_adder_pkg.sv */
// Adder peripheral definitions

package hc_adder_pkg;

	// Datapath and bus widths
	localparam int unsigned WORD_W = 24;
	localparam int unsigned ADDR_W = 5;
	localparam int unsigned CTRL_W = 3;

	// Kogge-Stone stages over the odd positions
	localparam int unsigned TREE_LEVELS = $clog2(WORD_W);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Register map, byte offsets
	localparam addr_t ADDR_A      = 5'h00;
	localparam addr_t ADDR_B      = 5'h04;
	localparam addr_t ADDR_CTRL   = 5'h08;
	localparam addr_t ADDR_RESULT = 5'h0c;
	localparam addr_t ADDR_STATUS = 5'h10;

	// Control word bits
	localparam int unsigned CTRL_GO  = 0;
	localparam int unsigned CTRL_SUB = 1;
	localparam int unsigned CTRL_CIN = 2;

	// Status word bits
	localparam int unsigned STAT_DONE  = 0;
	localparam int unsigned STAT_CARRY = 1;
	localparam int unsigned STAT_OVF   = 2;
	localparam int unsigned STAT_ZERO  = 3;

	// Launch sequencing
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		LAUNCH = 2'd1,
		BUSY   = 2'd2
	} launch_state_t;

endpackage

/* hw/han_carlson_tree.sv */
// Han-Carlson prefix network

`timescale 1ns/1ps

module han_carlson_tree (
	input  hc_adder_pkg::word_t      gen,
	input  hc_adder_pkg::word_t      prop,
	output wire hc_adder_pkg::word_t carry
);

	import hc_adder_pkg::*;

	// Group generate/propagate after each level, level 0 is the input
	wire word_t g_st [0:TREE_LEVELS];
	wire word_t p_st [0:TREE_LEVELS];

	genvar lvl, i;

	assign g_st[0] = gen;
	assign p_st[0] = prop;

	// Odd positions combine with the node 2**(lvl-1) below
	// Even positions and odd ones already reaching bit 0 pass through
	for (lvl = 1; lvl <= TREE_LEVELS; lvl++) begin : g_level
		for (i = 0; i < WORD_W; i++) begin : g_bit
			if ((i % 2 == 1) && (i >= (1 << (lvl - 1)))) begin : g_cell
				assign g_st[lvl][i] = g_st[lvl-1][i]
					| (p_st[lvl-1][i] & g_st[lvl-1][i - (1 << (lvl - 1))]);
				assign p_st[lvl][i] = p_st[lvl-1][i]
					& p_st[lvl-1][i - (1 << (lvl - 1))];
			end else begin : g_pass
				assign g_st[lvl][i] = g_st[lvl-1][i];
				assign p_st[lvl][i] = p_st[lvl-1][i];
			end
		end
	end

	// Extra grey stage, each even bit takes its odd neighbour below
	for (i = 0; i < WORD_W; i++) begin : g_post
		if ((i % 2 == 0) && (i > 0)) begin : g_grey
			assign carry[i] = g_st[TREE_LEVELS][i]
				| (p_st[TREE_LEVELS][i] & g_st[TREE_LEVELS][i-1]);
		end else begin : g_done
			// Bit 0 and odd bits already span down to 0
			assign carry[i] = g_st[TREE_LEVELS][i];
		end
	end

endmodule

/* hw/prefix_adder.sv */
// Registered prefix add/subtract

`timescale 1ns/1ps

module prefix_adder (
	input  logic                pclk,
	input  logic                rst_n,
	input  logic                start,
	input  hc_adder_pkg::word_t op_a,
	input  hc_adder_pkg::word_t op_b,
	input  logic                sub,
	input  logic                cin,
	output logic                res_valid,
	output hc_adder_pkg::word_t res_sum,
	output logic                res_carry,
	output logic                res_ovf,
	output logic                res_zero
);

	import hc_adder_pkg::*;

	word_t b_eff;
	word_t prop;
	word_t gen;
	word_t carry;
	word_t sum_d;
	logic  c_in;
	logic  ovf_d;

	// Subtract is A + ~B + 1
	assign b_eff = sub ? ~op_b : op_b;
	assign c_in  = sub | cin;

	assign prop = op_a ^ b_eff;
	// Carry-in folded into the bit 0 generate
	assign gen  = (op_a & b_eff) | word_t'(prop[0] & c_in);

	han_carlson_tree i_tree (
		.gen   (gen),
		.prop  (prop),
		.carry (carry)
	);

	assign sum_d = prop ^ {carry[WORD_W-2:0], c_in};

	// Operand signs agree but the sum sign differs
	assign ovf_d = (op_a[WORD_W-1] == b_eff[WORD_W-1]) && (sum_d[WORD_W-1] != op_a[WORD_W-1]);

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= start;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			res_sum   <= '0;
			res_carry <= 1'b0;
			res_ovf   <= 1'b0;
			res_zero  <= 1'b0;
		end else if (start) begin
			res_sum   <= sum_d;
			res_carry <= carry[WORD_W-1];
			res_ovf   <= ovf_d;
			res_zero  <= (sum_d == '0);
		end
	end

	// Tree output against a plain adder, one cycle after start
	a_result_follows_start: assert property (
		@(posedge pclk) disable iff (!rst_n)
		start |=> (res_valid
			&& ({res_carry, res_sum} == $past({1'b0, op_a} + {1'b0, b_eff} + c_in)))
	);

endmodule

/* hw/apb_operand_regs.sv */
// APB operand and control registers

`timescale 1ns/1ps

module apb_operand_regs (
	input  logic                                pclk,
	input  logic                                rst_n,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  hc_adder_pkg::addr_t                 paddr,
	input  logic [31:0]                         pwdata,
	output hc_adder_pkg::word_t                 op_a,
	output hc_adder_pkg::word_t                 op_b,
	output logic                                sub,
	output logic                                cin,
	output logic                                start,
	output logic                                launch,
	output logic [hc_adder_pkg::CTRL_W-1:0]     reg_ctrl,
	output logic                                wr_err
);

	import hc_adder_pkg::*;

	launch_state_t state;
	launch_state_t state_nxt;
	logic          wr_acc;
	logic          addr_ok;
	logic          go_wr;

	assign wr_acc  = psel && penable && pwrite;
	assign addr_ok = (paddr == ADDR_A) || (paddr == ADDR_B) || (paddr == ADDR_CTRL);
	assign wr_err  = wr_acc && !addr_ok;
	assign go_wr   = wr_acc && (paddr == ADDR_CTRL) && pwdata[CTRL_GO];

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			op_a     <= '0;
			op_b     <= '0;
			reg_ctrl <= '0;
		end else begin
			// Go reads back for one cycle only
			reg_ctrl[CTRL_GO] <= go_wr;
			if (wr_acc) begin
				case (paddr)
					ADDR_A: op_a <= pwdata[WORD_W-1:0];
					ADDR_B: op_b <= pwdata[WORD_W-1:0];
					ADDR_CTRL: begin
						reg_ctrl[CTRL_SUB] <= pwdata[CTRL_SUB];
						reg_ctrl[CTRL_CIN] <= pwdata[CTRL_CIN];
					end
					default: ;
				endcase
			end
		end
	end

	assign sub = reg_ctrl[CTRL_SUB];
	assign cin = reg_ctrl[CTRL_CIN];

	// A fresh go-write restarts from any state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    state_nxt = IDLE;
			LAUNCH:  state_nxt = BUSY;
			BUSY:    state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
		if (go_wr) begin
			state_nxt = LAUNCH;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign start  = (state == LAUNCH);
	assign launch = (state == LAUNCH);

	// Every start comes from a go-write on the bus one cycle before
	a_start_needs_go: assert property (
		@(posedge pclk) disable iff (!rst_n)
		start |-> $past(psel && penable && pwrite && (paddr == ADDR_CTRL) && pwdata[CTRL_GO])
	);

	// Rejected write leaves operands and control untouched
	a_wr_err_no_update: assert property (
		@(posedge pclk) disable iff (!rst_n)
		wr_err |=> ($stable(op_a) && $stable(op_b) && $stable(reg_ctrl[CTRL_CIN:CTRL_SUB]))
	);

endmodule

/* hw/result_regs.sv */
// Result capture and APB readback

`timescale 1ns/1ps

module result_regs (
	input  logic                            pclk,
	input  logic                            rst_n,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  hc_adder_pkg::addr_t             paddr,
	input  logic                            res_valid,
	input  hc_adder_pkg::word_t             res_sum,
	input  logic                            res_carry,
	input  logic                            res_ovf,
	input  logic                            res_zero,
	input  logic                            launch,
	input  hc_adder_pkg::word_t             reg_a,
	input  hc_adder_pkg::word_t             reg_b,
	input  logic [hc_adder_pkg::CTRL_W-1:0] reg_ctrl,
	input  logic                            wr_err,
	output logic [31:0]                     prdata,
	output logic                            pready,
	output logic                            pslverr
);

	import hc_adder_pkg::*;

	word_t       result;
	logic        carry_q;
	logic        ovf_q;
	logic        zero_q;
	logic        done;
	logic [31:0] status;
	logic [31:0] rd_data;
	logic        addr_hit;
	logic        rd_acc;
	logic        rd_err;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			result  <= '0;
			carry_q <= 1'b0;
			ovf_q   <= 1'b0;
			zero_q  <= 1'b0;
		end else if (res_valid) begin
			result  <= res_sum;
			carry_q <= res_carry;
			ovf_q   <= res_ovf;
			zero_q  <= res_zero;
		end
	end

	// New launch wins over a result still in flight
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else if (launch) begin
			done <= 1'b0;
		end else if (res_valid) begin
			done <= 1'b1;
		end
	end

	always_comb begin
		status             = '0;
		status[STAT_DONE]  = done;
		status[STAT_CARRY] = carry_q;
		status[STAT_OVF]   = ovf_q;
		status[STAT_ZERO]  = zero_q;
	end

	assign rd_acc = psel && penable && !pwrite;

	always_comb begin
		rd_data  = '0;
		addr_hit = 1'b1;
		case (paddr)
			ADDR_A:      rd_data = 32'(reg_a);
			ADDR_B:      rd_data = 32'(reg_b);
			ADDR_CTRL:   rd_data = 32'(reg_ctrl);
			ADDR_RESULT: rd_data = 32'(result);
			ADDR_STATUS: rd_data = status;
			default:     addr_hit = 1'b0;
		endcase
	end

	assign prdata  = rd_acc ? rd_data : '0;
	assign rd_err  = rd_acc && !addr_hit;
	// Write errors are decoded on the operand side
	assign pslverr = pwrite ? wr_err : rd_err;
	assign pready  = 1'b1;

	// Done rises two cycles after the launch that produced it
	a_done_after_valid: assert property (
		@(posedge pclk) disable iff (!rst_n)
		$rose(done) |-> ($past(res_valid) && $past(launch, 2))
	);

endmodule

/* hw/hc_adder_top.sv */
// Han-Carlson adder APB peripheral

`timescale 1ns/1ps

module hc_adder_top (
	input  logic                pclk,
	input  logic                rst_n,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  hc_adder_pkg::addr_t paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr
);

	import hc_adder_pkg::*;

	word_t             op_a;
	word_t             op_b;
	logic              sub;
	logic              cin;
	logic              start;
	logic              launch;
	logic [CTRL_W-1:0] reg_ctrl;
	logic              wr_err;
	logic              res_valid;
	word_t             res_sum;
	logic              res_carry;
	logic              res_ovf;
	logic              res_zero;

	apb_operand_regs i_operand_regs (
		.pclk     (pclk),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.op_a     (op_a),
		.op_b     (op_b),
		.sub      (sub),
		.cin      (cin),
		.start    (start),
		.launch   (launch),
		.reg_ctrl (reg_ctrl),
		.wr_err   (wr_err)
	);

	prefix_adder i_adder (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.start     (start),
		.op_a      (op_a),
		.op_b      (op_b),
		.sub       (sub),
		.cin       (cin),
		.res_valid (res_valid),
		.res_sum   (res_sum),
		.res_carry (res_carry),
		.res_ovf   (res_ovf),
		.res_zero  (res_zero)
	);

	result_regs i_result_regs (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.res_valid (res_valid),
		.res_sum   (res_sum),
		.res_carry (res_carry),
		.res_ovf   (res_ovf),
		.res_zero  (res_zero),
		.launch    (launch),
		.reg_a     (op_a),
		.reg_b     (op_b),
		.reg_ctrl  (reg_ctrl),
		.wr_err    (wr_err),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr)
	);

endmodule

/* bench/hc_adder_checker.sv */
// Adder peripheral APB checker

`timescale 1ns/1ps

module hc_adder_checker (
	input logic                pclk,
	input logic                rst_n,
	input logic                psel,
	input logic                penable,
	input logic                pwrite,
	input hc_adder_pkg::addr_t paddr,
	input logic [31:0]         pwdata,
	input logic [31:0]         prdata,
	input logic                pready,
	input logic                pslverr
);

	import hc_adder_pkg::*;

	int unsigned check_count = 0;
	int unsigned err_count = 0;
	int unsigned tests_run = 0;
	int unsigned tests_failed = 0;
	int unsigned test_err_base = 0;
	string       test_name;

	// Register model as software sees it
	word_t       mdl_a;
	word_t       mdl_b;
	logic        mdl_sub;
	logic        mdl_cin;
	logic        launched = 1'b0;

	// Expected result of the last launched operation
	word_t       exp_sum;
	logic        exp_carry;
	logic        exp_ovf;
	logic        exp_zero;

	// Values from the testbench table, {zero, ovf, carry}
	logic        ref_valid = 1'b0;
	word_t       ref_sum;
	logic [2:0]  ref_flags;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] t=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		err_count++;
		$display("t=%0t %s", $time, msg);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err_base = err_count;
	endtask

	task automatic finish_test();
		tests_run++;
		if (err_count == test_err_base) begin
			$display("PASS  %s", test_name);
		end else begin
			tests_failed++;
			$display("FAIL  %s (%0d errors)", test_name, err_count - test_err_base);
		end
	endtask

	task automatic expect_ref(input word_t sum, input logic carry, input logic ovf,
			input logic zero);
		ref_sum = sum;
		ref_flags = {zero, ovf, carry};
		ref_valid = 1'b1;
	endtask

	// Sum and flags straight from the arithmetic definition
	task automatic model_op(input word_t a, input word_t b, input logic sub, input logic cin);
		logic [WORD_W:0] total;
		word_t           b_used;
		logic            carry_in;
		int              sa;
		int              sb;
		int              ideal;
		b_used = sub ? ~b : b;
		carry_in = sub ? 1'b1 : cin;
		total = {1'b0, a} + {1'b0, b_used} + {{WORD_W{1'b0}}, carry_in};
		exp_sum = total[WORD_W-1:0];
		exp_carry = total[WORD_W];
		// Overflow when the true signed result leaves the 24-bit range
		sa = $signed(a);
		sb = $signed(b);
		ideal = sub ? (sa - sb) : (sa + sb + int'(cin));
		exp_ovf = (ideal >= (1 << (WORD_W - 1))) || (ideal < -(1 << (WORD_W - 1)));
		exp_zero = (exp_sum == '0);
	endtask

	function automatic logic mapped(input addr_t addr, input logic wr);
		logic hit;
		hit = (addr == ADDR_A) || (addr == ADDR_B) || (addr == ADDR_CTRL);
		if (!wr) begin
			hit = hit || (addr == ADDR_RESULT) || (addr == ADDR_STATUS);
		end
		return hit;
	endfunction

	// Control readback, go is self-clearing
	function automatic logic [31:0] ctrl_readback(input logic sub, input logic cin);
		logic [31:0] w;
		w = '0;
		w[CTRL_SUB] = sub;
		w[CTRL_CIN] = cin;
		return w;
	endfunction

	task automatic check_status();
		logic [31:0] exp;
		exp = '0;
		exp[STAT_DONE] = 1'b1;
		exp[STAT_CARRY] = exp_carry;
		exp[STAT_OVF] = exp_ovf;
		exp[STAT_ZERO] = exp_zero;
		if (!launched) begin
			compare("prdata STATUS", prdata, 32'd0);
		end else if (prdata[STAT_DONE]) begin
			compare("prdata STATUS", prdata, exp);
			if (ref_valid) begin
				ref_valid = 1'b0;
				if ({ref_sum, ref_flags} !== {exp_sum, exp_zero, exp_ovf, exp_carry}) begin
					report_failure("table row expected values disagree with the adder model");
				end
			end
		end
	endtask

	always @(posedge pclk) begin
		if (!rst_n) begin
			mdl_a = '0;
			mdl_b = '0;
			mdl_sub = 1'b0;
			mdl_cin = 1'b0;
			launched = 1'b0;
			exp_sum = '0;
			exp_carry = 1'b0;
			exp_ovf = 1'b0;
			exp_zero = 1'b0;
		end else if (psel && penable) begin
			compare("pready", 32'(pready), 32'd1);
			compare("pslverr", 32'(pslverr), 32'(!mapped(paddr, pwrite)));
			if (pwrite) begin
				case (paddr)
					ADDR_A: mdl_a = pwdata[WORD_W-1:0];
					ADDR_B: mdl_b = pwdata[WORD_W-1:0];
					ADDR_CTRL: begin
						mdl_sub = pwdata[CTRL_SUB];
						mdl_cin = pwdata[CTRL_CIN];
						if (pwdata[CTRL_GO]) begin
							model_op(mdl_a, mdl_b, mdl_sub, mdl_cin);
							launched = 1'b1;
						end
					end
					default: ;
				endcase
			end else begin
				case (paddr)
					ADDR_A:      compare("prdata A", prdata, 32'(mdl_a));
					ADDR_B:      compare("prdata B", prdata, 32'(mdl_b));
					ADDR_CTRL:   compare("prdata CTRL", prdata,
						ctrl_readback(mdl_sub, mdl_cin));
					ADDR_RESULT: compare("prdata RESULT", prdata, 32'(exp_sum));
					ADDR_STATUS: check_status();
					default: ;
				endcase
			end
		end
	end

endmodule

/* bench/tb_hc_adder.sv */
// Adder peripheral testbench

`timescale 1ns/1ps

module tb_hc_adder;

	import hc_adder_pkg::*;

	typedef struct packed {
		word_t a;
		word_t b;
		logic  sub;
		logic  cin;
		word_t sum;
		logic  carry;
		logic  ovf;
		logic  zero;
	} row_t;

	localparam int NUM_ROWS = 12;
	localparam int NUM_RAND = 16;
	// Three writes, a status poll and a result read, three cycles each
	localparam int CASE_CYCLES = 15;
	localparam int TIMEOUT_CYCLES = (NUM_ROWS + NUM_RAND + 4) * CASE_CYCLES + 200;

	logic        pclk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	addr_t       paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	row_t        rows [0:NUM_ROWS-1];
	logic [31:0] lfsr_state;
	int unsigned cycle_cnt = 0;

	hc_adder_top i_dut (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	hc_adder_checker i_chk (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		pclk = 1'b0;
		forever #50 pclk = ~pclk;
	end

	always @(posedge pclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without reaching the end", cycle_cnt);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Columns: a, b, sub, cin, sum, carry, ovf, zero
	task automatic fill_table();
		rows[0]  = {24'h000000, 24'h000000, 1'b0, 1'b0, 24'h000000, 1'b0, 1'b0, 1'b1};
		rows[1]  = {24'hffffff, 24'h000001, 1'b0, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b1};
		rows[2]  = {24'h7fffff, 24'h800001, 1'b0, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b1};
		rows[3]  = {24'h7fffff, 24'h000001, 1'b0, 1'b0, 24'h800000, 1'b0, 1'b1, 1'b0};
		rows[4]  = {24'h000500, 24'h000200, 1'b1, 1'b0, 24'h000300, 1'b1, 1'b0, 1'b0};
		rows[5]  = {24'h000200, 24'h000500, 1'b1, 1'b0, 24'hfffd00, 1'b0, 1'b0, 1'b0};
		rows[6]  = {24'h123456, 24'h123456, 1'b1, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b1};
		rows[7]  = {24'h800000, 24'h000001, 1'b1, 1'b0, 24'h7fffff, 1'b1, 1'b1, 1'b0};
		rows[8]  = {24'h800000, 24'h7fffff, 1'b0, 1'b0, 24'hffffff, 1'b0, 1'b0, 1'b0};
		rows[9]  = {24'h000010, 24'h000020, 1'b0, 1'b1, 24'h000031, 1'b0, 1'b0, 1'b0};
		// Carry-in has no effect on subtract
		rows[10] = {24'h000010, 24'h000001, 1'b1, 1'b1, 24'h00000f, 1'b1, 1'b0, 1'b0};
		rows[11] = {24'hffffff, 24'h000000, 1'b0, 1'b1, 24'h000000, 1'b1, 1'b0, 1'b1};
	endtask

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [31:0] ctrl_word(input logic go, input logic sub, input logic cin);
		logic [31:0] w;
		w = '0;
		w[CTRL_GO] = go;
		w[CTRL_SUB] = sub;
		w[CTRL_CIN] = cin;
		return w;
	endfunction

	task automatic apb_write(input addr_t addr, input logic [31:0] data);
		@(posedge pclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge pclk);
		penable <= 1'b1;
		@(posedge pclk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input addr_t addr, output logic [31:0] data);
		@(posedge pclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge pclk);
		penable <= 1'b1;
		@(posedge pclk);
		data = prdata;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_done();
		logic [31:0] status;
		int          polls;
		status = '0;
		polls = 0;
		while (!status[STAT_DONE] && polls < 8) begin
			apb_read(ADDR_STATUS, status);
			polls++;
		end
		if (!status[STAT_DONE]) begin
			i_chk.report_failure("done bit never set after the go-write");
		end
	endtask

	task automatic run_case(input word_t a, input word_t b, input logic sub, input logic cin);
		logic [31:0] data;
		apb_write(ADDR_A, 32'(a));
		apb_write(ADDR_B, 32'(b));
		apb_write(ADDR_CTRL, ctrl_word(1'b1, sub, cin));
		wait_done();
		apb_read(ADDR_RESULT, data);
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] data;
		word_t       ra;
		word_t       rb;
		logic        rs;
		logic        rc;

		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr_state = 32'h8e7f_33d4;
		fill_table();
		repeat (2) @(posedge pclk);
		rst_n <= 1'b1;

		// Status is clear out of reset, control write without go only stores
		i_chk.start_test("reset status and register readback");
		apb_read(ADDR_STATUS, data);
		apb_write(ADDR_A, 32'h00ab_cdef);
		apb_write(ADDR_B, 32'h0013_5795);
		apb_write(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 1'b1));
		apb_read(ADDR_A, data);
		apb_read(ADDR_B, data);
		apb_read(ADDR_CTRL, data);
		apb_read(ADDR_STATUS, data);
		i_chk.finish_test();

		for (int i = 0; i < NUM_ROWS; i++) begin
			i_chk.start_test($sformatf("table row %0d", i));
			i_chk.expect_ref(rows[i].sum, rows[i].carry, rows[i].ovf, rows[i].zero);
			run_case(rows[i].a, rows[i].b, rows[i].sub, rows[i].cin);
			i_chk.finish_test();
		end

		for (int n = 0; n < NUM_RAND; n++) begin
			take_bits(24, rnd);
			ra = rnd[23:0];
			take_bits(24, rnd);
			rb = rnd[23:0];
			take_bits(1, rnd);
			rs = rnd[0];
			take_bits(1, rnd);
			rc = rnd[0];
			i_chk.start_test($sformatf("random case %0d", n));
			run_case(ra, rb, rs, rc);
			i_chk.finish_test();
		end

		// Bad accesses must error and leave every register as it was
		i_chk.start_test("APB error responses");
		apb_write(ADDR_RESULT, 32'h00a5_5a5a);
		apb_write(ADDR_STATUS, 32'h0000_000f);
		apb_write(addr_t'(5'h14), 32'h0012_3456);
		apb_read(addr_t'(5'h14), data);
		apb_read(ADDR_A, data);
		apb_read(ADDR_B, data);
		apb_read(ADDR_CTRL, data);
		apb_read(ADDR_RESULT, data);
		apb_read(ADDR_STATUS, data);
		i_chk.finish_test();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			i_chk.tests_run, i_chk.tests_failed, i_chk.check_count, i_chk.err_count);
		if (i_chk.err_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
hw/hc_adder_pkg.sv
hw/han_carlson_tree.sv
hw/prefix_adder.sv
hw/apb_operand_regs.sv
hw/result_regs.sv
hw/hc_adder_top.sv
bench/hc_adder_checker.sv
bench/tb_hc_adder.sv

/* Bender.yml */
package:
  name: hc_adder

sources:
  - files:
      - hw/hc_adder_pkg.sv
      - hw/han_carlson_tree.sv
      - hw/prefix_adder.sv
      - hw/apb_operand_regs.sv
      - hw/result_regs.sv
      - hw/hc_adder_top.sv
  - target: test
    files:
      - bench/hc_adder_checker.sv
      - bench/tb_hc_adder.sv
